// File: dtim_pkg.sv
package dtim_pkg;

  localparam int dtim_depth = 4;  // Index bits, 16 lines
  localparam int dtim_width = 1;  // Word-select bits, 2 words per line
  localparam int tag_bits = 30 - dtim_depth - dtim_width;
  localparam int line_bits = 64;

  localparam logic [31:0] dtim_base_addr = 32'h0000_0000;
  localparam logic [31:0] dtim_top_addr = 32'h0000_0200;  // First address that bypasses

  localparam int mem_words = 256;
  localparam int mem_latency = 2;  // Cycles from first valid to ready

  // Used on both the core side and the backing side
  typedef struct packed {
    logic valid;
    logic fence;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // One write port and one read port per storage array
  typedef struct packed {
    logic wen;
    logic [dtim_depth-1:0] waddr;
    logic [dtim_depth-1:0] raddr;
    logic [line_bits-1:0] wdata;  // Narrow arrays take the low bits
  } array_in_t;

  typedef struct packed {
    logic [line_bits-1:0] rdata;
  } array_out_t;

  typedef enum logic [2:0] {
    s_hit,
    s_miss,
    s_ldst,
    s_update,
    s_fence,
    s_writeback
  } dtim_state_e;

endpackage

// File: dtim_array.sv
`timescale 1ns/1ps

module dtim_array #(
  parameter int data_bits = 64
) (
  input logic clk,
  input dtim_pkg::array_in_t wr,
  output dtim_pkg::array_out_t rd
);

  logic [data_bits-1:0] mem [2**dtim_pkg::dtim_depth] = '{default: '0};
  logic [data_bits-1:0] rdata;

  always_ff @(posedge clk) begin
    if (wr.wen) begin
      mem[wr.waddr] <= wr.wdata[data_bits-1:0];
    end
    rdata <= mem[wr.raddr];  // Old contents on a same-index write
  end

  always_comb begin
    rd.rdata = '0;
    rd.rdata[data_bits-1:0] = rdata;
  end

endmodule

// File: dtim_ctrl.sv
`timescale 1ns/1ps

module dtim_ctrl (
  input logic clk,
  input logic rst,
  input dtim_pkg::mem_req_t req,
  output dtim_pkg::mem_rsp_t rsp,
  output dtim_pkg::array_in_t tag_in,
  output dtim_pkg::array_in_t data_in,
  output dtim_pkg::array_in_t lock_in,
  output dtim_pkg::array_in_t dirty_in,
  input dtim_pkg::array_out_t tag_out,
  input dtim_pkg::array_out_t data_out,
  input dtim_pkg::array_out_t lock_out,
  input dtim_pkg::array_out_t dirty_out,
  output dtim_pkg::mem_req_t mem_req,
  input dtim_pkg::mem_rsp_t mem_rsp
);

  typedef struct packed {
    logic load;
    logic store;
    logic fence;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0] strb;
    logic [dtim_pkg::tag_bits-1:0] tag;
    logic [dtim_pkg::dtim_depth-1:0] did;
    logic [dtim_pkg::dtim_width-1:0] wid;
  } front_t;

  typedef struct packed {
    dtim_pkg::dtim_state_e state;
    logic [dtim_pkg::tag_bits-1:0] tag;
    logic [dtim_pkg::dtim_depth-1:0] did;
    logic [dtim_pkg::dtim_width-1:0] wid;
    logic [dtim_pkg::dtim_width-1:0] cnt;
    logic [dtim_pkg::line_bits-1:0] line;
    logic [31:0] wdata;
    logic [3:0] strb;
    logic store;
    dtim_pkg::mem_req_t mem;
    dtim_pkg::mem_rsp_t rsp;
  } back_t;

  front_t r_f;
  front_t rin_f;
  back_t r_b;
  back_t rin_b;

  logic in_range;
  logic tag_match;
  logic line_wen;  // Tag and data arrays
  logic flag_wen;  // Lock and dirty arrays
  logic lock_val;
  logic dirty_val;
  logic [dtim_pkg::dtim_depth-1:0] w_idx;
  logic [dtim_pkg::dtim_depth-1:0] rd_idx;

  function automatic logic [dtim_pkg::line_bits-1:0] merge_store(
    input logic [dtim_pkg::line_bits-1:0] line,
    input logic [dtim_pkg::dtim_width-1:0] wid,
    input logic [31:0] wdata,
    input logic [3:0] strb
  );
    logic [dtim_pkg::line_bits-1:0] res;
    res = line;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[32*wid + 8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Moves the fence walk to the next index, or finishes it on the last one
  function automatic back_t fence_step(input back_t b);
    back_t n;
    n = b;
    if (b.did == '1) begin
      n.state = dtim_pkg::s_hit;
      n.rsp.ready = 1'b1;
      n.rsp.rdata = '0;
    end else begin
      n.state = dtim_pkg::s_fence;
      n.did = b.did + 1'b1;
    end
    return n;
  endfunction

  assign in_range = (r_f.addr - dtim_pkg::dtim_base_addr) <
                    (dtim_pkg::dtim_top_addr - dtim_pkg::dtim_base_addr);
  assign tag_match = tag_out.rdata[dtim_pkg::tag_bits-1:0] == r_f.tag;

  always_comb begin
    rin_f = r_f;
    rin_f.load = 1'b0;
    rin_f.store = 1'b0;
    rin_f.fence = 1'b0;
    if (req.valid) begin
      rin_f.fence = req.fence;
      rin_f.store = !req.fence && (req.wstrb != 4'h0);
      rin_f.load = !req.fence && (req.wstrb == 4'h0);
      rin_f.addr = req.addr;
      rin_f.data = req.wdata;
      rin_f.strb = req.wstrb;
      rin_f.tag = req.addr[31 -: dtim_pkg::tag_bits];
      rin_f.did = req.addr[2 + dtim_pkg::dtim_width +: dtim_pkg::dtim_depth];
      rin_f.wid = req.addr[2 +: dtim_pkg::dtim_width];
    end
  end

  always_comb begin
    rin_b = r_b;
    rin_b.rsp.ready = 1'b0;
    rin_b.mem.fence = 1'b0;
    line_wen = 1'b0;
    flag_wen = 1'b0;
    lock_val = 1'b0;
    dirty_val = 1'b0;
    case (r_b.state)
      dtim_pkg::s_hit: begin
        rin_b.tag = r_f.tag;
        rin_b.did = r_f.did;
        rin_b.wid = r_f.wid;
        rin_b.wdata = r_f.data;
        rin_b.strb = r_f.strb;
        rin_b.store = r_f.store;
        if (r_f.fence) begin
          rin_b.state = dtim_pkg::s_fence;
          rin_b.did = '0;
        end else if (r_f.load || r_f.store) begin
          if (!in_range || (lock_out.rdata[0] && !tag_match)) begin
            rin_b.state = dtim_pkg::s_ldst;  // Uncached access
            rin_b.mem.valid = 1'b1;
            rin_b.mem.addr = r_f.addr;
            rin_b.mem.wdata = r_f.data;
            rin_b.mem.wstrb = r_f.strb;
          end else if (!lock_out.rdata[0]) begin
            rin_b.state = dtim_pkg::s_miss;
            rin_b.cnt = '0;
            rin_b.mem.valid = 1'b1;
            rin_b.mem.addr = {r_f.addr[31:dtim_pkg::dtim_width+2],
                              {(dtim_pkg::dtim_width+2){1'b0}}};
            rin_b.mem.wstrb = 4'h0;
          end else if (r_f.store) begin
            rin_b.state = dtim_pkg::s_update;
            rin_b.line = merge_store(data_out.rdata, r_f.wid, r_f.data, r_f.strb);
            line_wen = 1'b1;
            flag_wen = 1'b1;
            lock_val = 1'b1;
            dirty_val = 1'b1;
          end else begin
            rin_b.rsp.ready = 1'b1;
            rin_b.rsp.rdata = data_out.rdata[32*r_f.wid +: 32];
          end
        end
      end
      dtim_pkg::s_miss: begin
        if (mem_rsp.ready) begin
          rin_b.line[32*r_b.cnt +: 32] = mem_rsp.rdata;
          if (r_b.cnt == '1) begin
            rin_b.state = dtim_pkg::s_update;
            rin_b.mem.valid = 1'b0;
            if (r_b.store) begin
              rin_b.line = merge_store(rin_b.line, r_b.wid, r_b.wdata, r_b.strb);
            end
            line_wen = 1'b1;
            flag_wen = 1'b1;
            lock_val = 1'b1;
            dirty_val = r_b.store;
          end else begin
            rin_b.cnt = r_b.cnt + 1'b1;
            rin_b.mem.addr = r_b.mem.addr + 32'd4;
          end
        end
      end
      dtim_pkg::s_ldst: begin
        if (mem_rsp.ready) begin
          rin_b.state = dtim_pkg::s_hit;
          rin_b.mem.valid = 1'b0;
          rin_b.rsp.ready = 1'b1;
          rin_b.rsp.rdata = mem_rsp.rdata;
        end
      end
      dtim_pkg::s_update: begin
        rin_b.state = dtim_pkg::s_hit;
        rin_b.rsp.ready = 1'b1;
        rin_b.rsp.rdata = r_b.line[32*r_b.wid +: 32];
      end
      dtim_pkg::s_fence: begin
        flag_wen = 1'b1;  // Every visited line is unlocked and cleaned
        if (lock_out.rdata[0] && dirty_out.rdata[0]) begin
          rin_b.state = dtim_pkg::s_writeback;
          rin_b.line = data_out.rdata;
          rin_b.cnt = '0;
          rin_b.mem.valid = 1'b1;
          rin_b.mem.addr = {tag_out.rdata[dtim_pkg::tag_bits-1:0], r_b.did,
                            {(dtim_pkg::dtim_width+2){1'b0}}};
          rin_b.mem.wdata = data_out.rdata[31:0];
          rin_b.mem.wstrb = 4'hf;
        end else begin
          rin_b = fence_step(rin_b);
        end
      end
      dtim_pkg::s_writeback: begin
        if (mem_rsp.ready) begin
          if (r_b.cnt == '1) begin
            rin_b.mem.valid = 1'b0;
            rin_b = fence_step(rin_b);
          end else begin
            rin_b.cnt = r_b.cnt + 1'b1;
            rin_b.mem.addr = r_b.mem.addr + 32'd4;
            rin_b.mem.wdata = r_b.line[32*rin_b.cnt +: 32];
          end
        end
      end
      default: begin
        rin_b.state = dtim_pkg::s_hit;
      end
    endcase
  end

  // Reads follow the index the back end will look at next cycle
  assign rd_idx = (rin_b.state == dtim_pkg::s_fence) ? rin_b.did : rin_f.did;
  assign w_idx = (r_b.state == dtim_pkg::s_hit) ? r_f.did : r_b.did;

  always_comb begin
    tag_in.wen = line_wen;
    tag_in.waddr = w_idx;
    tag_in.raddr = rd_idx;
    tag_in.wdata = {{(dtim_pkg::line_bits - dtim_pkg::tag_bits){1'b0}}, rin_b.tag};
    data_in.wen = line_wen;
    data_in.waddr = w_idx;
    data_in.raddr = rd_idx;
    data_in.wdata = rin_b.line;
    lock_in.wen = flag_wen;
    lock_in.waddr = w_idx;
    lock_in.raddr = rd_idx;
    lock_in.wdata = {{(dtim_pkg::line_bits - 1){1'b0}}, lock_val};
    dirty_in.wen = flag_wen;
    dirty_in.waddr = w_idx;
    dirty_in.raddr = rd_idx;
    dirty_in.wdata = {{(dtim_pkg::line_bits - 1){1'b0}}, dirty_val};
  end

  assign rsp = r_b.rsp;
  assign mem_req = r_b.mem;

  always_ff @(posedge clk) begin
    if (!rst) begin
      r_f.load <= 1'b0;
      r_f.store <= 1'b0;
      r_f.fence <= 1'b0;
      r_b.state <= dtim_pkg::s_hit;
      r_b.mem.valid <= 1'b0;
      r_b.rsp.ready <= 1'b0;
    end else begin
      r_f <= rin_f;
      r_b <= rin_b;
    end
  end

endmodule

// File: dtim.sv
`timescale 1ns/1ps

module dtim (
  input logic clk,
  input logic rst,
  input dtim_pkg::mem_req_t req,
  output dtim_pkg::mem_rsp_t rsp,
  output dtim_pkg::mem_req_t mem_req,
  input dtim_pkg::mem_rsp_t mem_rsp
);

  dtim_pkg::array_in_t tag_in;
  dtim_pkg::array_in_t data_in;
  dtim_pkg::array_in_t lock_in;
  dtim_pkg::array_in_t dirty_in;
  dtim_pkg::array_out_t tag_out;
  dtim_pkg::array_out_t data_out;
  dtim_pkg::array_out_t lock_out;
  dtim_pkg::array_out_t dirty_out;

  dtim_array #(.data_bits(dtim_pkg::tag_bits)) tag_array (
    .clk(clk),
    .wr(tag_in),
    .rd(tag_out)
  );

  dtim_array #(.data_bits(dtim_pkg::line_bits)) data_array (
    .clk(clk),
    .wr(data_in),
    .rd(data_out)
  );

  dtim_array #(.data_bits(1)) lock_array (
    .clk(clk),
    .wr(lock_in),
    .rd(lock_out)
  );

  dtim_array #(.data_bits(1)) dirty_array (
    .clk(clk),
    .wr(dirty_in),
    .rd(dirty_out)
  );

  dtim_ctrl ctrl (
    .clk(clk),
    .rst(rst),
    .req(req),
    .rsp(rsp),
    .tag_in(tag_in),
    .data_in(data_in),
    .lock_in(lock_in),
    .dirty_in(dirty_in),
    .tag_out(tag_out),
    .data_out(data_out),
    .lock_out(lock_out),
    .dirty_out(dirty_out),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

endmodule

// File: backing_mem.sv
`timescale 1ns/1ps

module backing_mem (
  input logic clk,
  input logic rst,
  input dtim_pkg::mem_req_t req,
  output dtim_pkg::mem_rsp_t rsp
);

  logic [31:0] mem [dtim_pkg::mem_words] = '{default: '0};
  logic [$clog2(dtim_pkg::mem_words)-1:0] idx;
  logic [7:0] cnt;
  logic ready;
  logic done;
  logic [31:0] rdata;

  assign idx = req.addr[2 +: $clog2(dtim_pkg::mem_words)];

  // Last counted cycle of a transaction; ready goes out on the next one
  assign done = req.valid && !ready && (cnt == 8'(dtim_pkg::mem_latency - 1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      cnt <= '0;
      ready <= 1'b0;
    end else begin
      ready <= done;
      if (done) begin
        cnt <= '0;
      end else if (req.valid && !ready) begin
        cnt <= cnt + 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
      rdata <= mem[idx];  // A write returns the old word
    end
  end

  assign rsp.ready = ready;
  assign rsp.rdata = rdata;

endmodule

// File: dtim_top.sv
`timescale 1ns/1ps

module dtim_top (
  input logic clk,
  input logic rst,
  input dtim_pkg::mem_req_t req,
  output dtim_pkg::mem_rsp_t rsp
);

  dtim_pkg::mem_req_t mem_req;
  dtim_pkg::mem_rsp_t mem_rsp;

  dtim dtim_inst (
    .clk(clk),
    .rst(rst),
    .req(req),
    .rsp(rsp),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  backing_mem mem_inst (
    .clk(clk),
    .rst(rst),
    .req(mem_req),
    .rsp(mem_rsp)
  );

endmodule

// File: dtim_tb.sv
`timescale 1ns/1ps

module dtim_tb;

  localparam int random_ops = 64;
  localparam int fence_cost = 16 * 2 * (dtim_pkg::mem_latency + 2);

  logic clk = 1'b0;
  logic rst;
  dtim_pkg::mem_req_t req;
  dtim_pkg::mem_rsp_t rsp;

  logic [31:0] shadow [dtim_pkg::mem_words];
  logic locked [16];  // Model of which line is resident
  logic [24:0] line_tag [16];
  logic [15:0] lfsr = 16'd17668;
  int cycles = 0;
  int limit = 0;

  string t_name [$];
  string t_op [$];
  logic [31:0] t_addr [$];
  logic [31:0] t_wdata [$];
  logic [3:0] t_strb [$];
  logic [31:0] t_exp [$];

  dtim_top dut (
    .clk(clk),
    .rst(rst),
    .req(req),
    .rsp(rsp)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout: no response arrived within %0d cycles", limit);
      $display("Test failures found");
      $fatal(1);
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED %s (%s): expected %h, actual %h", name, what, exp, act);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic read_tests();
    int fd;
    int n;
    string line;
    string name;
    string op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    fd = $fopen("dtim_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file dtim_tests.txt");
      $display("Test failures found");
      $fatal(1);
    end
    while ($fgets(line, fd)) begin
      n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, d, s, e);
      if (n == 6 && name.substr(0, 0) != "#") begin
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(a);
        t_wdata.push_back(d);
        t_strb.push_back(s[3:0]);
        t_exp.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // Predicts a hit from the lock and tag rules and tracks which lines are resident
  task automatic update_model(input logic is_fence, input logic [31:0] addr,
                              output logic hit);
    logic [3:0] idx;
    idx = addr[6:3];
    hit = 1'b0;
    if (is_fence) begin
      for (int i = 0; i < 16; i++) begin
        locked[i] = 1'b0;
      end
    end else if (addr < dtim_pkg::dtim_top_addr) begin
      if (!locked[idx]) begin
        locked[idx] = 1'b1;
        line_tag[idx] = addr[31:7];
      end else if (line_tag[idx] == addr[31:7]) begin
        hit = 1'b1;
      end
    end
  endtask

  task automatic run_op(input logic is_fence, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] strb,
                        output logic [31:0] rdata, output int lat);
    dtim_pkg::mem_req_t r;
    r.valid = 1'b1;
    r.fence = is_fence;
    r.addr = addr;
    r.wdata = wdata;
    r.wstrb = strb;
    lat = 0;
    @(posedge clk);
    req <= r;
    do begin
      @(posedge clk);
      lat++;
      if (lat == 1) begin
        req.valid <= 1'b0;
      end
      @(negedge clk);
    end while (!rsp.ready);
    rdata = rsp.rdata;
  endtask

  // Runs one operation and checks data and hit latency
  task automatic check_op(input string name, input logic is_fence, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          input logic [31:0] exp);
    logic hit;
    logic [31:0] rdata;
    int lat;
    int exp_lat;
    update_model(is_fence, addr, hit);
    run_op(is_fence, addr, wdata, strb, rdata, lat);
    if (is_fence) begin
      assert (rdata == 32'h0) else report_mismatch(name, "fence rdata", 32'h0, rdata);
    end else if (strb == 4'h0) begin
      assert (rdata == exp) else report_mismatch(name, "load rdata", exp, rdata);
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          shadow[addr[9:2]][8*i +: 8] = wdata[8*i +: 8];
        end
      end
    end
    if (hit) begin
      exp_lat = (strb != 4'h0) ? 3 : 2;
      assert (lat == exp_lat) else report_mismatch(name, "hit latency", exp_lat, lat);
    end
  endtask

  initial begin
    logic [31:0] kind;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] addr;
    rst = 1'b0;
    req = '0;
    for (int i = 0; i < dtim_pkg::mem_words; i++) begin
      shadow[i] = 32'h0;
    end
    for (int i = 0; i < 16; i++) begin
      locked[i] = 1'b0;
      line_tag[i] = '0;
    end
    read_tests();
    limit = (t_name.size() + random_ops) * fence_cost + 40;
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);

    foreach (t_name[i]) begin
      check_op(t_name[i], t_op[i] == "F", t_addr[i], t_wdata[i],
               (t_op[i] == "S") ? t_strb[i] : 4'h0, t_exp[i]);
    end

    for (int i = 0; i < random_ops; i++) begin
      take_bits(3, kind);
      take_bits(7, a);
      take_bits(32, d);
      take_bits(4, s);
      addr = {a[6] ? 32'h200 : 32'h0} + {a[5:0], 2'b00};  // Low DTIM range or bypass
      if (kind == 0) begin
        check_op($sformatf("rand_%0d_fence", i), 1'b1, 32'h0, 32'h0, 4'h0, 32'h0);
      end else if (kind < 4) begin
        check_op($sformatf("rand_%0d_load", i), 1'b0, addr, 32'h0, 4'h0,
                 shadow[addr[9:2]]);
      end else begin
        check_op($sformatf("rand_%0d_store", i), 1'b0, addr, d,
                 (s[3:0] == 4'h0) ? 4'hf : s[3:0], 32'h0);
      end
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: dtim_tests.txt
# name op(L/S/F) addr wdata strb expected_rdata, all numbers in hex
# Expected data is checked for loads and fences only
ld_cold L 00000000 00000000 0 00000000
st_miss S 00000008 11111111 f 00000000
ld_hit1 L 00000008 00000000 0 11111111
st_hit S 0000000c 22222222 f 00000000
ld_w1 L 0000000c 00000000 0 22222222
st_b0 S 00000008 000000aa 1 00000000
ld_b0 L 00000008 00000000 0 111111aa
st_b23 S 00000008 bbcc0000 c 00000000
ld_b23 L 00000008 00000000 0 bbcc11aa
st_high S 00000200 cafef00d f 00000000
ld_high L 00000200 00000000 0 cafef00d
st_high2 S 000003fc 12345678 3 00000000
ld_high2 L 000003fc 00000000 0 00005678
st_conf S 00000080 deadbeef f 00000000
ld_conf L 00000080 00000000 0 deadbeef
ld_conf2 L 00000084 00000000 0 00000000
st_idx0 S 00000004 a5a5a5a5 f 00000000
ld_idx0 L 00000004 00000000 0 a5a5a5a5
fence1 F 00000000 00000000 0 00000000
ld_wb1 L 00000008 00000000 0 bbcc11aa
ld_wb2 L 0000000c 00000000 0 22222222
ld_wb3 L 00000004 00000000 0 a5a5a5a5
ld_conf3 L 00000080 00000000 0 deadbeef
fence2 F 00000000 00000000 0 00000000
ld_conf4 L 00000080 00000000 0 deadbeef
ld_old0 L 00000000 00000000 0 00000000
st_last S 000001f8 0f0f0f0f f 00000000
ld_last L 000001f8 00000000 0 0f0f0f0f
fence3 F 00000000 00000000 0 00000000
ld_last2 L 000001f8 00000000 0 0f0f0f0f
st_last3 S 000001fc 00ff00ff 5 00000000
ld_last3 L 000001fc 00000000 0 00ff00ff
fence4 F 00000000 00000000 0 00000000
ld_last4 L 000001fc 00000000 0 00ff00ff

// File: src.f
dtim_pkg.sv
dtim_array.sv
dtim_ctrl.sv
dtim.sv
backing_mem.sv
dtim_top.sv
dtim_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dtim_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
